// File: sim.f
hdl/warp_pkg.sv
hdl/lane_alu.sv
hdl/warp_decoder.sv
hdl/warp_control.sv
hdl/warp_regfile.sv
hdl/warp_mem_port.sv
hdl/warp_core.sv
bench/warp_core_assert.sv
bench/warp_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module warp_core_tb -f sim.f -o warp_sim
./obj_dir/warp_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log

// File: bench/warp_core_tb.sv
`timescale 1ns/1ps

module warp_core_tb;

    logic              clk;
    logic              reset;
    warp_pkg::wb_req_t bus_req;
    warp_pkg::wb_rsp_t bus_rsp;
    logic              halted;

    logic [31:0] mem [256];
    logic [31:0] store_adr [$];
    logic [31:0] store_dat [$];
    logic [31:0] prog [$];
    logic        pending;
    int          wait_left;
    int          cycles;
    int          errors;
    int          max_cycles;

    warp_core i_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] r_op(input logic s, input logic [3:0] f,
                                         input logic [4:0] rd, rs1, rs2);
        return {3'b000, s, 9'b0, rs2, f, rs1, rd};
    endfunction

    function automatic logic [31:0] i_op(input logic s, input logic [3:0] f,
                                         input logic [4:0] rd, rs1, input logic [31:0] imm);
        return {3'b001, s, imm[13:0], f, rs1, rd};
    endfunction

    function automatic logic [31:0] lw_op(input logic s, input logic [4:0] rd, rs1,
                                          input logic [31:0] imm);
        return {3'b011, imm[14:0], s, 3'b000, rs1, rd};
    endfunction

    function automatic logic [31:0] sw_op(input logic s, input logic [4:0] rs1, rs2,
                                          input logic [31:0] imm);
        return {3'b011, imm[14:5], rs2, s, 3'b001, rs1, imm[4:0]}; // Offset split around rs2
    endfunction

    function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
        return {3'b100, imm, 3'b000, 1'b1, rd}; // Scalar destination
    endfunction

    function automatic logic [31:0] jal_op(input logic [31:0] off);
        return {3'b111, off[25:10], 3'b000, off[9:0]};
    endfunction

    function automatic logic [31:0] branch_op(input logic [2:0] f, input logic [4:0] rs1,
                                              input logic [31:0] off);
        return {3'b111, off[15:6], 5'b0, off[5], f, rs1, off[4:0]};
    endfunction

    function automatic logic [31:0] exit_op();
        return {3'b111, 16'b0, 3'b111, 10'b0};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'h5eed0000 ^ (addr * 32'h00009e37);
    endfunction

    function automatic int writes_to(input logic [31:0] addr);
        int hits;
        hits = 0;
        foreach (store_adr[i])
            if (store_adr[i] == addr)
                hits++;
        return hits;
    endfunction

    // Wishbone slave with 0 to 2 wait states per access
    always @(posedge clk) begin
        #1;
        bus_rsp.ack = 1'b0;
        if (reset || !(bus_req.cyc && bus_req.stb)) begin
            pending = 1'b0;
        end else begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $urandom % 3;
            end
            if (wait_left == 0) begin
                bus_rsp.ack = 1'b1;
                if (bus_req.we) begin
                    mem[bus_req.adr[9:2]] = bus_req.dat;
                    store_adr.push_back(bus_req.adr);
                    store_dat.push_back(bus_req.dat);
                end else begin
                    bus_rsp.dat = mem[bus_req.adr[9:2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    task automatic load_program();
        for (int w = 0; w < 256; w++)
            mem[w] = fill_word(w * 4);
        prog = {};
        prog.push_back(i_op(1'b0, 4'b0010, 5'd1, 5'd31, 3));    // v1 = lane * 3
        prog.push_back(i_op(1'b0, 4'b0000, 5'd1, 5'd1, 5));
        prog.push_back(i_op(1'b0, 4'b1010, 5'd2, 5'd31, 2));    // v2 = lane * 4
        prog.push_back(sw_op(1'b0, 5'd2, 5'd1, 32'h300));
        prog.push_back(i_op(1'b0, 4'b0000, 5'd3, 5'd0, 7));
        prog.push_back(r_op(1'b0, 4'b0001, 5'd4, 5'd3, 5'd1));  // SUB
        prog.push_back(sw_op(1'b0, 5'd2, 5'd4, 32'h310));
        prog.push_back(r_op(1'b0, 4'b0101, 5'd5, 5'd1, 5'd31)); // SLL
        prog.push_back(sw_op(1'b0, 5'd2, 5'd5, 32'h320));
        prog.push_back(r_op(1'b0, 4'b1000, 5'd6, 5'd4, 5'd31)); // MIN
        prog.push_back(sw_op(1'b0, 5'd2, 5'd6, 32'h330));
        prog.push_back(r_op(1'b0, 4'b1001, 5'd7, 5'd4, 5'd0));  // ABS
        prog.push_back(sw_op(1'b0, 5'd2, 5'd7, 32'h340));
        prog.push_back(i_op(1'b1, 4'b0000, 5'd1, 5'd0, 42));    // Scalar s1
        prog.push_back(sw_op(1'b1, 5'd0, 5'd1, 32'h350));
        prog.push_back(lw_op(1'b0, 5'd8, 5'd2, 32'h200));
        prog.push_back(lw_op(1'b0, 5'd9, 5'd2, 32'h210));
        prog.push_back(r_op(1'b0, 4'b0000, 5'd10, 5'd8, 5'd9));
        prog.push_back(sw_op(1'b0, 5'd2, 5'd10, 32'h360));
        prog.push_back(lui_op(5'd5, 20'h12345));
        prog.push_back(sw_op(1'b1, 5'd0, 5'd5, 32'h370));
        prog.push_back(r_op(1'b0, 4'b0100, 5'd11, 5'd4, 5'd31)); // SLT
        prog.push_back(sw_op(1'b0, 5'd2, 5'd11, 32'h380));
        prog.push_back(r_op(1'b0, 4'b0110, 5'd12, 5'd7, 5'd3));  // SEQ
        prog.push_back(sw_op(1'b0, 5'd2, 5'd12, 32'h390));
        prog.push_back(i_op(1'b0, 4'b1011, 5'd13, 5'd31, 2));    // SEQI
        prog.push_back(sw_op(1'b0, 5'd2, 5'd13, 32'h3a0));
        prog.push_back(r_op(1'b0, 4'b0111, 5'd14, 5'd6, 5'd0));  // SNEZ
        prog.push_back(sw_op(1'b0, 5'd2, 5'd14, 32'h3b0));
        prog.push_back(branch_op(3'b001, 5'd0, 1));              // BEQZ over next store
        prog.push_back(sw_op(1'b1, 5'd0, 5'd1, 32'h3c0));
        prog.push_back(i_op(1'b1, 4'b0000, 5'd2, 5'd0, 3));
        prog.push_back(i_op(1'b1, 4'b0000, 5'd3, 5'd3, 1));      // Loop top
        prog.push_back(i_op(1'b1, 4'b0000, 5'd2, 5'd2, -1));
        prog.push_back(r_op(1'b1, 4'b0111, 5'd4, 5'd2, 5'd0));
        prog.push_back(branch_op(3'b010, 5'd4, -4));             // BEQO back to top
        prog.push_back(sw_op(1'b1, 5'd0, 5'd3, 32'h3d0));
        prog.push_back(jal_op(1));
        prog.push_back(sw_op(1'b1, 5'd0, 5'd1, 32'h3e0));
        prog.push_back(exit_op());
        foreach (prog[i])
            mem[i] = prog[i];
    endtask

    task automatic check_word(input logic [31:0] addr, input logic [31:0] expected);
        int          hits;
        logic [31:0] seen;
        hits = 0;
        seen = '0;
        foreach (store_adr[i]) begin
            if (store_adr[i] == addr) begin
                hits++;
                seen = store_dat[i];
            end
        end
        assert (hits == 1 && seen == expected) else begin
            errors++;
            $display("error at %0t: word %h written %0d times with %h, expected %h once",
                     $time, addr, hits, seen, expected);
        end
    endtask

    task automatic check_results();
        int v1;
        int v4;
        int v6;
        int v7;
        int a;
        for (int l = 0; l < warp_pkg::NUM_LANES; l++) begin
            a  = 4 * l;
            v1 = l * 3 + 5;
            v4 = 7 - v1;
            v6 = (v4 < l) ? v4 : l;
            v7 = (v4 < 0) ? -v4 : v4;
            check_word(32'h300 + a, v1);
            check_word(32'h310 + a, v4);
            check_word(32'h320 + a, v1 << l);
            check_word(32'h330 + a, v6);
            check_word(32'h340 + a, v7);
            check_word(32'h360 + a, fill_word(32'h200 + a) + fill_word(32'h210 + a));
            check_word(32'h380 + a, 32'(v4 < l));
            check_word(32'h390 + a, 32'(v7 == 7));
            check_word(32'h3a0 + a, 32'(l == 2));
            check_word(32'h3b0 + a, 32'(v6 != 0));
        end
        check_word(32'h350, 42);
        check_word(32'h370, 32'h12345000);
        check_word(32'h3d0, 3); // Loop passes
        assert (writes_to(32'h3c0) == 0 && writes_to(32'h3e0) == 0) else begin
            errors++;
            $display("error at %0t: a skipped store reached the bus", $time);
        end
        assert (store_adr.size() == 10 * warp_pkg::NUM_LANES + 3) else begin
            errors++;
            $display("error at %0t: %0d bus writes seen", $time, store_adr.size());
        end
    endtask

    initial begin
        void'($urandom(32'hccf6));
        clk        = 1'b0;
        reset      = 1'b1;
        bus_rsp    = '0;
        pending    = 1'b0;
        wait_left  = 0;
        errors     = 0;
        cycles     = 0;
        max_cycles = 60 * 60 + 400; // Instructions times worst case plus margin
        load_program();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        while (!halted && cycles < max_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("Timeout: the core did not halt within %0d cycles", max_cycles);
        end else begin
            repeat (20) @(posedge clk); // Bus must stay idle after EXIT
            check_results();
        end
        $display("Run ended after %0d cycles: %0d check errors, %0d assertion errors",
                 cycles, errors, i_dut.i_core_assert.fail_count);
        if (errors == 0 && i_dut.i_core_assert.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: bench/warp_core_assert.sv
`timescale 1ns/1ps

module warp_core_assert (
    input logic              clk,
    input logic              reset,
    input warp_pkg::wb_req_t bus_req,
    input warp_pkg::wb_rsp_t bus_rsp,
    input logic              halted
);

    int fail_count = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        bus_req.stb |-> bus_req.cyc)
        else begin
            fail_count++;
            $error("stb high without cyc");
        end

    // Request held until ack
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (bus_req.stb && !bus_rsp.ack) |=>
            (bus_req.stb && $stable(bus_req.adr) && $stable(bus_req.we)))
        else begin
            fail_count++;
            $error("adr or we changed while waiting for ack");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped");
        end

    halt_idle: assert property (@(posedge clk) disable iff (reset)
        halted |-> (!bus_req.cyc && !bus_req.stb))
        else begin
            fail_count++;
            $error("bus active after halt");
        end

    reset_idle: assert property (@(posedge clk)
        reset |=> !bus_req.cyc)
        else begin
            fail_count++;
            $error("cyc high in the cycle after reset");
        end

endmodule

bind warp_core warp_core_assert i_core_assert (.*);

// File: hdl/warp_core.sv
`timescale 1ns/1ps

module warp_core (
    input  logic              clk,
    input  logic              reset,
    output warp_pkg::wb_req_t bus_req,
    input  warp_pkg::wb_rsp_t bus_rsp,
    output logic              halted
);

    warp_pkg::warp_state_t           warp_state;
    warp_pkg::decoded_t              decoded;
    logic [warp_pkg::DATA_WIDTH-1:0] pc;
    logic [warp_pkg::DATA_WIDTH-1:0] instruction;
    logic [warp_pkg::DATA_WIDTH-1:0] fetch_data;
    logic                            mem_start;
    logic                            mem_fetch;
    logic                            mem_done;
    logic                            rf_write;
    logic                            branch_taken;
    logic [warp_pkg::NUM_LANES-1:0]  zero_flag;
    logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] rs1_data;
    logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] rs2_data;
    logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] alu_result;
    logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] lane_result;
    logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] load_data;

    // Branches only look at the scalar operand seen by lane 0
    assign branch_taken = decoded.branch && decoded.scalar && zero_flag[0];

    always_ff @(posedge clk) begin
        if (warp_state == warp_pkg::WARP_EXECUTE)
            lane_result <= alu_result;
    end

    warp_control  i_control (.*);
    warp_decoder  i_decoder (.*);
    warp_regfile  i_regfile (.*);

    warp_mem_port i_mem_port (
        .addresses  (lane_result),
        .store_data (rs2_data),
        .*
    );

    for (genvar l = 0; l < warp_pkg::NUM_LANES; l++) begin : g_lane
        lane_alu i_alu (
            .decoded   (decoded),
            .a         (rs1_data[l]),
            .b         (rs2_data[l]),
            .result    (alu_result[l]),
            .zero_flag (zero_flag[l])
        );
    end

endmodule

// File: hdl/warp_mem_port.sv
`timescale 1ns/1ps

module warp_mem_port (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic                                                     mem_start,
    input  logic                                                     mem_fetch,
    input  logic [warp_pkg::DATA_WIDTH-1:0]                          pc,
    input  warp_pkg::decoded_t                                       decoded,
    input  logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] addresses,
    input  logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] store_data,
    output warp_pkg::wb_req_t                                        bus_req,
    input  warp_pkg::wb_rsp_t                                        bus_rsp,
    output logic                                                     mem_done,
    output logic [warp_pkg::DATA_WIDTH-1:0]                          fetch_data,
    output logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] load_data
);

    logic [warp_pkg::LANE_BITS-1:0] lane;
    logic                           last_access;
    logic                           acked;

    assign acked       = bus_req.cyc && bus_rsp.ack;
    assign last_access = mem_fetch || decoded.scalar || (lane == warp_pkg::LAST_LANE);
    assign mem_done    = acked && last_access;
    assign fetch_data  = bus_rsp.dat; // Control latches it on mem_done

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_req.cyc <= 1'b0;
            bus_req.stb <= 1'b0;
            bus_req.we  <= 1'b0;
            lane        <= '0;
        end else if (acked) begin
            bus_req.cyc <= 1'b0; // Drop for one cycle between lanes
            bus_req.stb <= 1'b0;
            bus_req.we  <= 1'b0;
            lane        <= last_access ? '0 : lane + 1'b1;
        end else if (!bus_req.cyc && mem_start) begin
            bus_req.cyc <= 1'b1;
            bus_req.stb <= 1'b1;
            bus_req.we  <= !mem_fetch && decoded.mem_write;
            bus_req.adr <= mem_fetch ? pc : addresses[lane];
            bus_req.dat <= store_data[lane];
        end
    end

    always_ff @(posedge clk) begin
        if (acked && !mem_fetch)
            load_data[lane] <= bus_rsp.dat;
    end

endmodule

// File: hdl/warp_regfile.sv
`timescale 1ns/1ps

module warp_regfile (
    input  logic                                                       clk,
    input  logic                                                       reset,
    input  warp_pkg::decoded_t                                         decoded,
    input  logic                                                       rf_write,
    input  logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0]   lane_result,
    input  logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0]   load_data,
    output logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0]   rs1_data,
    output logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0]   rs2_data
);

    logic [warp_pkg::DATA_WIDTH-1:0] sregs [warp_pkg::NUM_REGS];
    logic [warp_pkg::DATA_WIDTH-1:0] vregs [warp_pkg::NUM_LANES][warp_pkg::NUM_REGS];
    logic [warp_pkg::NUM_LANES-1:0][warp_pkg::DATA_WIDTH-1:0] wr_data;

    function automatic logic [warp_pkg::DATA_WIDTH-1:0] operand(
        input int                                lane,
        input logic [warp_pkg::REG_ADDR_WIDTH-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (decoded.scalar)
            return sregs[addr]; // Same scalar value on every lane
        else if (addr == warp_pkg::LANE_ID_REG)
            return lane;
        else
            return vregs[lane][addr];
    endfunction

    always_comb begin
        for (int l = 0; l < warp_pkg::NUM_LANES; l++) begin
            rs1_data[l] = operand(l, decoded.rs1);
            rs2_data[l] = operand(l, decoded.rs2);
            case (decoded.wb_src)
                warp_pkg::LSU_OUT:   wr_data[l] = load_data[l];
                warp_pkg::IMMEDIATE: wr_data[l] = decoded.immediate;
                default:             wr_data[l] = lane_result[l];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < warp_pkg::NUM_REGS; r++) begin
                sregs[r] <= '0;
                for (int l = 0; l < warp_pkg::NUM_LANES; l++)
                    vregs[l][r] <= '0;
            end
        end else if (rf_write && decoded.rd != '0) begin
            if (decoded.scalar) begin
                sregs[decoded.rd] <= wr_data[0];
            end else begin
                for (int l = 0; l < warp_pkg::NUM_LANES; l++)
                    vregs[l][decoded.rd] <= wr_data[l];
            end
        end
    end

endmodule

// File: hdl/warp_control.sv
`timescale 1ns/1ps

module warp_control (
    input  logic                            clk,
    input  logic                            reset,
    input  warp_pkg::decoded_t              decoded,
    input  logic [warp_pkg::DATA_WIDTH-1:0] fetch_data,
    input  logic                            mem_done,
    input  logic                            branch_taken,
    output warp_pkg::warp_state_t           warp_state,
    output logic [warp_pkg::DATA_WIDTH-1:0] pc,
    output logic [warp_pkg::DATA_WIDTH-1:0] instruction,
    output logic                            mem_start,
    output logic                            mem_fetch,
    output logic                            rf_write,
    output logic                            halted
);

    logic                            taken_q;
    logic [warp_pkg::DATA_WIDTH-1:0] pc_next_seq;
    logic [warp_pkg::DATA_WIDTH-1:0] branch_offset;

    // Port holds a bus request while either state lasts
    assign mem_fetch = (warp_state == warp_pkg::WARP_FETCH);
    assign mem_start = mem_fetch || (warp_state == warp_pkg::WARP_MEMORY);
    assign rf_write  = (warp_state == warp_pkg::WARP_WRITEBACK) && decoded.reg_write;
    assign halted    = (warp_state == warp_pkg::WARP_DONE);

    assign pc_next_seq   = pc + 32'd4;
    assign branch_offset = {decoded.immediate[warp_pkg::DATA_WIDTH-3:0], 2'b00}; // Word offset

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_state <= warp_pkg::WARP_FETCH;
            pc         <= '0;
            taken_q    <= 1'b0;
        end else begin
            case (warp_state)
                warp_pkg::WARP_FETCH: begin
                    if (mem_done)
                        warp_state <= warp_pkg::WARP_DECODE;
                end
                warp_pkg::WARP_DECODE: warp_state <= warp_pkg::WARP_EXECUTE;
                warp_pkg::WARP_EXECUTE: begin
                    taken_q <= branch_taken;
                    if (decoded.halt)
                        warp_state <= warp_pkg::WARP_DONE;
                    else if (decoded.mem_read || decoded.mem_write)
                        warp_state <= warp_pkg::WARP_MEMORY;
                    else
                        warp_state <= warp_pkg::WARP_WRITEBACK;
                end
                warp_pkg::WARP_MEMORY: begin
                    if (mem_done)
                        warp_state <= warp_pkg::WARP_WRITEBACK;
                end
                warp_pkg::WARP_WRITEBACK: begin
                    if (decoded.alu_op == warp_pkg::JAL || taken_q)
                        pc <= pc_next_seq + branch_offset;
                    else
                        pc <= pc_next_seq;
                    warp_state <= warp_pkg::WARP_FETCH;
                end
                default: ; // WARP_DONE holds until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_fetch && mem_done)
            instruction <= fetch_data;
    end

endmodule

// File: hdl/warp_decoder.sv
`timescale 1ns/1ps

module warp_decoder (
    input  logic                               clk,
    input  logic                               reset,
    input  warp_pkg::warp_state_t              warp_state,
    input  logic [warp_pkg::DATA_WIDTH-1:0]    instruction,
    output warp_pkg::decoded_t                 decoded
);

    warp_pkg::opcode_t  opcode;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [2:0]         funct3;
    logic [3:0]         funct4;
    logic [13:0]        imm_i;
    logic [14:0]        imm_load;
    logic [14:0]        imm_s;
    logic [15:0]        imm_b;
    logic [19:0]        imm_u;
    logic [25:0]        imm_j;
    warp_pkg::decoded_t dec_next;

    assign opcode   = warp_pkg::opcode_t'(instruction[31:29]);
    assign rd       = instruction[4:0];
    assign rs1      = instruction[9:5];
    assign rs2      = instruction[18:14];
    assign funct3   = instruction[12:10];
    assign funct4   = instruction[13:10];
    assign imm_i    = instruction[27:14];
    assign imm_load = instruction[28:14];
    assign imm_s    = {instruction[28:19], instruction[4:0]}; // Split around rs2
    assign imm_b    = {instruction[28:19], instruction[13], instruction[4:0]};
    assign imm_u    = instruction[28:9];
    assign imm_j    = {instruction[28:13], instruction[9:0]};

    always_comb begin
        dec_next = '0; // Anything unrecognized stays a no-op
        case (opcode)
            warp_pkg::OPCODE_R: begin
                dec_next.rd        = rd;
                dec_next.rs1       = rs1;
                dec_next.rs2       = rs2;
                dec_next.reg_write = 1'b1;
                dec_next.scalar    = instruction[28];
                case (funct4)
                    4'b0000: dec_next.alu_op = warp_pkg::ADD;
                    4'b0001: dec_next.alu_op = warp_pkg::SUB;
                    4'b0010: dec_next.alu_op = warp_pkg::MUL;
                    4'b0100: dec_next.alu_op = warp_pkg::SLT;
                    4'b0101: dec_next.alu_op = warp_pkg::SLL;
                    4'b0110: dec_next.alu_op = warp_pkg::SEQ;
                    4'b0111: dec_next.alu_op = warp_pkg::SNEZ;
                    4'b1000: dec_next.alu_op = warp_pkg::MIN;
                    4'b1001: dec_next.alu_op = warp_pkg::ABS;
                    default: dec_next = '0;
                endcase
            end
            warp_pkg::OPCODE_I: begin
                dec_next.rd        = rd;
                dec_next.rs1       = rs1;
                dec_next.reg_write = 1'b1;
                dec_next.scalar    = instruction[28];
                dec_next.immediate = {{18{imm_i[13]}}, imm_i};
                case (funct4)
                    4'b0000: dec_next.alu_op = warp_pkg::ADDI;
                    4'b0010: dec_next.alu_op = warp_pkg::MULI;
                    4'b1010: dec_next.alu_op = warp_pkg::SLLI;
                    4'b1011: dec_next.alu_op = warp_pkg::SEQI;
                    default: dec_next = '0;
                endcase
            end
            warp_pkg::OPCODE_F: begin
                // Float ops decode as no-ops without an FPU
            end
            warp_pkg::OPCODE_M: begin
                dec_next.rs1    = rs1;
                dec_next.scalar = instruction[13];
                dec_next.alu_op = warp_pkg::ADDI; // Effective address
                if (funct3 == 3'b000) begin // LW
                    dec_next.rd        = rd;
                    dec_next.reg_write = 1'b1;
                    dec_next.mem_read  = 1'b1;
                    dec_next.wb_src    = warp_pkg::LSU_OUT;
                    dec_next.immediate = {{17{imm_load[14]}}, imm_load};
                end else if (funct3 == 3'b001) begin // SW
                    dec_next.rs2       = rs2;
                    dec_next.mem_write = 1'b1;
                    dec_next.immediate = {{17{imm_s[14]}}, imm_s};
                end else begin
                    dec_next = '0;
                end
            end
            warp_pkg::OPCODE_UP: begin
                dec_next.rd        = rd;
                dec_next.reg_write = 1'b1;
                dec_next.wb_src    = warp_pkg::IMMEDIATE;
                dec_next.immediate = {imm_u, 12'b0};
                dec_next.scalar    = instruction[5];
            end
            warp_pkg::OPCODE_J: begin
                case (funct3)
                    3'b000: begin
                        dec_next.alu_op    = warp_pkg::JAL;
                        dec_next.immediate = {{6{imm_j[25]}}, imm_j};
                        dec_next.scalar    = 1'b1;
                    end
                    3'b001, 3'b010: begin
                        dec_next.rs1       = rs1;
                        dec_next.branch    = 1'b1;
                        dec_next.immediate = {{16{imm_b[15]}}, imm_b};
                        dec_next.alu_op    = funct3[0] ? warp_pkg::BEQZ : warp_pkg::BEQO;
                        dec_next.scalar    = 1'b1;
                    end
                    3'b111: begin // EXIT
                        dec_next.halt   = 1'b1;
                        dec_next.scalar = 1'b1;
                    end
                    default: dec_next = '0;
                endcase
            end
            default: dec_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (warp_state == warp_pkg::WARP_DECODE) begin
            decoded <= dec_next;
        end
    end

endmodule

// File: hdl/lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
    input  warp_pkg::decoded_t              decoded,
    input  logic [warp_pkg::DATA_WIDTH-1:0] a,
    input  logic [warp_pkg::DATA_WIDTH-1:0] b,
    output logic [warp_pkg::DATA_WIDTH-1:0] result,
    output logic                            zero_flag
);

    logic [warp_pkg::DATA_WIDTH-1:0] operand_b;

    always_comb begin
        case (decoded.alu_op)
            warp_pkg::ADDI, warp_pkg::MULI,
            warp_pkg::SLLI, warp_pkg::SEQI: operand_b = decoded.immediate;
            default:                        operand_b = b;
        endcase

        result = '0;
        case (decoded.alu_op)
            warp_pkg::ADD, warp_pkg::ADDI:  result = a + operand_b;
            warp_pkg::SUB:                  result = a - operand_b;
            warp_pkg::MUL, warp_pkg::MULI:  result = a * operand_b; // Low word only
            warp_pkg::SLT:                  result[0] = $signed(a) < $signed(operand_b);
            warp_pkg::SLL, warp_pkg::SLLI:  result = a << operand_b[4:0];
            warp_pkg::SEQ, warp_pkg::SEQI:  result[0] = (a == operand_b);
            warp_pkg::SNEZ:                 result[0] = (a != '0);
            warp_pkg::MIN:  result = ($signed(a) < $signed(operand_b)) ? a : operand_b;
            warp_pkg::ABS:  result = a[warp_pkg::DATA_WIDTH-1] ? -a : a;
            default: ; // JAL and branches produce no value
        endcase

        // Set when the branch condition holds
        case (decoded.alu_op)
            warp_pkg::BEQZ: zero_flag = (a == '0);
            warp_pkg::BEQO: zero_flag = (a == 32'd1);
            default:        zero_flag = 1'b0;
        endcase
    end

endmodule

// File: hdl/warp_pkg.sv
package warp_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int NUM_LANES = 4;
    localparam int LANE_BITS = $clog2(NUM_LANES);
    localparam logic [LANE_BITS-1:0] LAST_LANE = LANE_BITS'(NUM_LANES - 1);
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;
    localparam logic [REG_ADDR_WIDTH-1:0] LANE_ID_REG = REG_ADDR_WIDTH'(31); // Read-only lane index

    // Major opcode in instruction bits 31:29
    typedef enum logic [2:0] {
        OPCODE_R  = 3'b000,
        OPCODE_I  = 3'b001,
        OPCODE_F  = 3'b010,
        OPCODE_M  = 3'b011,
        OPCODE_UP = 3'b100,
        OPCODE_J  = 3'b111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, MUL, SLT, SLL, SEQ, SNEZ, MIN, ABS,
        ADDI, MULI, SLLI, SEQI,
        JAL, BEQZ, BEQO
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_OUT,
        LSU_OUT,
        IMMEDIATE
    } wb_src_t;

    typedef enum logic [2:0] {
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_MEMORY,
        WARP_WRITEBACK,
        WARP_DONE
    } warp_state_t;

    typedef struct packed {
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      branch;
        logic                      halt;
        logic                      scalar;
        wb_src_t                   wb_src;
        logic [DATA_WIDTH-1:0]     immediate;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        alu_op_t                   alu_op;
    } decoded_t;

    // Wishbone classic master request and slave response
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [DATA_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage
